// ==== cgra_pkg.sv ====
`default_nettype none

package cgra_pkg;

    // host and datapath widths
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 20;

    // context memory geometry
    localparam int CM_WIDTH     = 64;
    localparam int CM_DEPTH     = 16;
    localparam int CM_ADDR_BITS = 4;

    // one host write fills one lane of a context word
    localparam int LANE_WIDTH = 16;
    localparam int NUM_LANES  = 4;
    localparam int LANE_BITS  = $clog2(NUM_LANES);

    // array size
    localparam int NUM_TILES_X  = 2;
    localparam int NUM_TILES_Y  = 2;
    localparam int NUM_TILES    = NUM_TILES_X * NUM_TILES_Y;
    localparam int TILE_ID_BITS = 2;

    // host address fields
    localparam int REGION_LSB  = 18;
    localparam int REGION_BITS = 2;
    localparam int TILE_LSB    = 7;
    localparam int WORD_LSB    = 3;
    localparam int LANE_LSB    = 1;

    // context word fields
    localparam int OPCODE_LSB  = 0;
    localparam int OPCODE_BITS = 4;
    localparam int TARGET_LSB  = 8;
    localparam int OPERAND_LSB = 16;

    typedef enum logic [REGION_BITS-1:0] {
        REGION_CM  = 2'b00,
        REGION_ACC = 2'b01
    } region_e;

    // zero decodes as nop, so a cleared memory is a harmless program
    typedef enum logic [OPCODE_BITS-1:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_XOR  = 4'h2,
        OP_JUMP = 4'h3,
        OP_HALT = 4'hf
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_DONE = 2'b10
    } exec_state_e;

endpackage

`default_nettype wire

// ==== context_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module context_mem (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wr_en,
    input  logic [cgra_pkg::CM_ADDR_BITS-1:0] wr_addr,
    input  logic [cgra_pkg::CM_ADDR_BITS-1:0] rd_addr,
    input  logic [cgra_pkg::CM_WIDTH-1:0]     wr_data,
    input  logic [cgra_pkg::CM_WIDTH-1:0]     bit_en,
    output logic [cgra_pkg::CM_WIDTH-1:0]     rd_data
);

    logic [cgra_pkg::CM_WIDTH-1:0] mem [cgra_pkg::CM_DEPTH];

    // unloaded words read back as zero and execute as nop
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cgra_pkg::CM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            // only masked bits change
            mem[wr_addr] <= (mem[wr_addr] & ~bit_en) | (wr_data & bit_en);
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// ==== cfg_write_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_write_decoder (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              chip_en,
    input  logic                              read_write,
    input  logic                              scan_data_or_addr,
    input  logic                              scan_start_exec,
    input  logic                              running,
    input  logic [cgra_pkg::ADDR_WIDTH-1:0]   address_in,
    input  logic [cgra_pkg::DATA_WIDTH-1:0]   data_in,
    input  logic [1:0]                        data_addr_valid,
    output logic [cgra_pkg::CM_WIDTH-1:0]     cm_wr_data,
    output logic [cgra_pkg::CM_WIDTH-1:0]     cm_bit_en,
    output logic [cgra_pkg::NUM_TILES-1:0]    tile_wr_sel,
    output logic [cgra_pkg::CM_ADDR_BITS-1:0] word_addr
);

    cgra_pkg::region_e                 region;
    logic [cgra_pkg::LANE_BITS-1:0]    lane;
    logic [cgra_pkg::TILE_ID_BITS-1:0] tile_idx;
    logic [cgra_pkg::LANE_WIDTH-1:0]   byte_mask;
    logic                              wr_strobe;

    assign region    = cgra_pkg::region_e'(address_in[cgra_pkg::REGION_LSB +:
                                                      cgra_pkg::REGION_BITS]);
    assign lane      = address_in[cgra_pkg::LANE_LSB +: cgra_pkg::LANE_BITS];
    assign tile_idx  = address_in[cgra_pkg::TILE_LSB +: cgra_pkg::TILE_ID_BITS];
    assign word_addr = address_in[cgra_pkg::WORD_LSB +: cgra_pkg::CM_ADDR_BITS];

    // bit 1 enables the upper byte of the lane, bit 0 the lower
    assign byte_mask = {{(cgra_pkg::LANE_WIDTH/2){data_addr_valid[1]}},
                        {(cgra_pkg::LANE_WIDTH/2){data_addr_valid[0]}}};

    // lane data and mask shifted into place in the context word
    assign cm_wr_data = {{(cgra_pkg::CM_WIDTH-cgra_pkg::LANE_WIDTH){1'b0}},
                         data_in[cgra_pkg::LANE_WIDTH-1:0] & byte_mask}
                        << (lane * cgra_pkg::LANE_WIDTH);
    assign cm_bit_en  = {{(cgra_pkg::CM_WIDTH-cgra_pkg::LANE_WIDTH){1'b0}}, byte_mask}
                        << (lane * cgra_pkg::LANE_WIDTH);

    // no write while the array is executing
    assign wr_strobe = chip_en && read_write && !scan_start_exec && !scan_data_or_addr
                       && !running && (region == cgra_pkg::REGION_CM)
                       && (data_addr_valid != 2'b00);

    assign tile_wr_sel = wr_strobe ? ({{(cgra_pkg::NUM_TILES-1){1'b0}}, 1'b1} << tile_idx)
                                   : '0;

endmodule

`default_nettype wire

// ==== tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              chip_en,
    input  logic                              running,
    input  logic                              wr_sel,
    input  logic [cgra_pkg::CM_ADDR_BITS-1:0] word_addr,
    input  logic [cgra_pkg::CM_WIDTH-1:0]     cm_wr_data,
    input  logic [cgra_pkg::CM_WIDTH-1:0]     cm_bit_en,
    output logic [cgra_pkg::CM_WIDTH-1:0]     cm_rd_data,
    output logic [cgra_pkg::DATA_WIDTH-1:0]   acc,
    output logic                              halted
);

    logic [cgra_pkg::CM_ADDR_BITS-1:0] pc;
    logic [cgra_pkg::CM_ADDR_BITS-1:0] rd_addr;
    cgra_pkg::opcode_e                 opcode;
    logic [cgra_pkg::DATA_WIDTH-1:0]   operand;
    logic [cgra_pkg::CM_ADDR_BITS-1:0] target;
    logic                              idle_q;
    logic                              first;
    logic                              halted_q;

    // host word address while idle, program counter while running
    assign rd_addr = running ? pc : word_addr;

    context_mem i_cm (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_sel),
        .wr_addr (word_addr),
        .rd_addr (rd_addr),
        .wr_data (cm_wr_data),
        .bit_en  (cm_bit_en),
        .rd_data (cm_rd_data)
    );

    // instruction fields
    assign opcode  = cgra_pkg::opcode_e'(cm_rd_data[cgra_pkg::OPCODE_LSB +:
                                                    cgra_pkg::OPCODE_BITS]);
    assign operand = cm_rd_data[cgra_pkg::OPERAND_LSB +: cgra_pkg::DATA_WIDTH];
    assign target  = cm_rd_data[cgra_pkg::TARGET_LSB +: cgra_pkg::CM_ADDR_BITS];

    // first running cycle clears state, no instruction issues
    assign first = running && idle_q;

    // stale halt from the previous run must not end the new one
    assign halted = halted_q && !first;

    always_ff @(posedge clk) begin
        if (reset) begin
            idle_q   <= 1'b1;
            pc       <= '0;
            acc      <= '0;
            halted_q <= 1'b0;
        end else if (chip_en) begin
            idle_q <= !running;
            if (first) begin
                pc       <= '0;
                acc      <= '0;
                halted_q <= 1'b0;
            end else if (running && !halted_q) begin
                case (opcode)
                    cgra_pkg::OP_ADD: begin
                        acc <= acc + operand;
                        pc  <= pc + 1'b1;
                    end
                    cgra_pkg::OP_XOR: begin
                        acc <= acc ^ operand;
                        pc  <= pc + 1'b1;
                    end
                    cgra_pkg::OP_JUMP: begin
                        pc <= target;
                    end
                    cgra_pkg::OP_HALT: begin
                        halted_q <= 1'b1;
                    end
                    // nop and undefined codes just advance
                    default: begin
                        pc <= pc + 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== exec_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_control (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           chip_en,
    input  logic                           scan_start_exec,
    input  logic [cgra_pkg::NUM_TILES-1:0] halted,
    output logic                           running,
    output logic                           exec_end
);

    cgra_pkg::exec_state_e state;
    cgra_pkg::exec_state_e state_next;
    logic                  all_halted;

    assign all_halted = &halted;

    always_comb begin
        state_next = state;
        case (state)
            cgra_pkg::ST_IDLE, cgra_pkg::ST_DONE: begin
                if (scan_start_exec) begin
                    state_next = cgra_pkg::ST_RUN;
                end
            end
            // start strobes during a run are dropped
            cgra_pkg::ST_RUN: begin
                if (all_halted) begin
                    state_next = cgra_pkg::ST_DONE;
                end
            end
            default: begin
                state_next = cgra_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cgra_pkg::ST_IDLE;
        end else if (chip_en) begin
            state <= state_next;
        end
    end

    // both decoded straight from the state register
    assign running  = (state == cgra_pkg::ST_RUN);
    assign exec_end = (state == cgra_pkg::ST_DONE);

endmodule

`default_nettype wire

// ==== readback_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module readback_mux (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            chip_en,
    input  logic                            read_write,
    input  logic                            scan_start_exec,
    input  logic                            running,
    input  logic [cgra_pkg::ADDR_WIDTH-1:0] address_in,
    input  logic [cgra_pkg::CM_WIDTH-1:0]   cm_rd_data [cgra_pkg::NUM_TILES],
    input  logic [cgra_pkg::DATA_WIDTH-1:0] acc [cgra_pkg::NUM_TILES],
    output logic [cgra_pkg::DATA_WIDTH-1:0] data_out,
    output logic                            data_out_valid
);

    cgra_pkg::region_e                 region;
    logic [cgra_pkg::TILE_ID_BITS-1:0] tile_idx;
    logic [cgra_pkg::LANE_BITS-1:0]    lane_idx;
    logic [cgra_pkg::CM_WIDTH-1:0]     lane_word;
    logic [cgra_pkg::DATA_WIDTH-1:0]   rd_value;
    logic                              rd_strobe;

    assign region   = cgra_pkg::region_e'(address_in[cgra_pkg::REGION_LSB +:
                                                     cgra_pkg::REGION_BITS]);
    assign tile_idx = address_in[cgra_pkg::TILE_LSB +: cgra_pkg::TILE_ID_BITS];
    assign lane_idx = address_in[cgra_pkg::LANE_LSB +: cgra_pkg::LANE_BITS];

    // addressed lane moved down to bit 0
    assign lane_word = cm_rd_data[tile_idx] >> (lane_idx * cgra_pkg::LANE_WIDTH);

    always_comb begin
        case (region)
            cgra_pkg::REGION_CM: begin
                rd_value = {{(cgra_pkg::DATA_WIDTH-cgra_pkg::LANE_WIDTH){1'b0}},
                            lane_word[cgra_pkg::LANE_WIDTH-1:0]};
            end
            cgra_pkg::REGION_ACC: begin
                rd_value = acc[tile_idx];
            end
            default: begin
                rd_value = '0;
            end
        endcase
    end

    // reads are only served while idle
    assign rd_strobe = !read_write && !scan_start_exec && !running;

    always_ff @(posedge clk) begin
        if (reset) begin
            data_out       <= '0;
            data_out_valid <= 1'b0;
        end else if (chip_en) begin
            data_out_valid <= rd_strobe;
            if (rd_strobe) begin
                data_out <= rd_value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cgra_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cgra_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            chip_en,
    input  logic                            scan_start_exec,
    input  logic                            scan_data_or_addr,
    input  logic                            read_write,
    input  logic                            bist_en,
    input  logic [cgra_pkg::DATA_WIDTH-1:0] data_in,
    input  logic [cgra_pkg::ADDR_WIDTH-1:0] address_in,
    input  logic [1:0]                      data_addr_valid,
    output logic [cgra_pkg::DATA_WIDTH-1:0] data_out,
    output logic                            data_out_valid,
    output logic                            exec_end
);

    logic [cgra_pkg::CM_WIDTH-1:0]     cm_wr_data;
    logic [cgra_pkg::CM_WIDTH-1:0]     cm_bit_en;
    logic [cgra_pkg::NUM_TILES-1:0]    tile_wr_sel;
    logic [cgra_pkg::CM_ADDR_BITS-1:0] word_addr;
    logic [cgra_pkg::NUM_TILES-1:0]    halted;
    logic                              running;
    logic [cgra_pkg::CM_WIDTH-1:0]     cm_rd_data [cgra_pkg::NUM_TILES];
    logic [cgra_pkg::DATA_WIDTH-1:0]   acc [cgra_pkg::NUM_TILES];

    cfg_write_decoder i_decoder (
        .clk               (clk),
        .reset             (reset),
        .chip_en           (chip_en),
        .read_write        (read_write),
        .scan_data_or_addr (scan_data_or_addr),
        .scan_start_exec   (scan_start_exec),
        .running           (running),
        .address_in        (address_in),
        .data_in           (data_in),
        .data_addr_valid   (data_addr_valid),
        .cm_wr_data        (cm_wr_data),
        .cm_bit_en         (cm_bit_en),
        .tile_wr_sel       (tile_wr_sel),
        .word_addr         (word_addr)
    );

    // tile index is row * NUM_TILES_X + column
    for (genvar t = 0; t < cgra_pkg::NUM_TILES; t++) begin : g_tile
        tile i_tile (
            .clk        (clk),
            .reset      (reset),
            .chip_en    (chip_en),
            .running    (running),
            .wr_sel     (tile_wr_sel[t]),
            .word_addr  (word_addr),
            .cm_wr_data (cm_wr_data),
            .cm_bit_en  (cm_bit_en),
            .cm_rd_data (cm_rd_data[t]),
            .acc        (acc[t]),
            .halted     (halted[t])
        );
    end

    exec_control i_exec (
        .clk             (clk),
        .reset           (reset),
        .chip_en         (chip_en),
        .scan_start_exec (scan_start_exec),
        .halted          (halted),
        .running         (running),
        .exec_end        (exec_end)
    );

    readback_mux i_readback (
        .clk             (clk),
        .reset           (reset),
        .chip_en         (chip_en),
        .read_write      (read_write),
        .scan_start_exec (scan_start_exec),
        .running         (running),
        .address_in      (address_in),
        .cm_rd_data      (cm_rd_data),
        .acc             (acc),
        .data_out        (data_out),
        .data_out_valid  (data_out_valid)
    );

endmodule

`default_nettype wire

// ==== cgra_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cgra_chk (
    input logic                           clk,
    input logic                           reset,
    input logic                           chip_en,
    input logic                           read_write,
    input logic                           scan_start_exec,
    input logic                           running,
    input logic                           exec_end,
    input logic                           data_out_valid,
    input logic [cgra_pkg::NUM_TILES-1:0] tile_wr_sel
);

    // at most one tile takes a context write
    wr_sel_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(tile_wr_sel))
        else $error("tile_wr_sel selects more than one tile");

    run_end_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(exec_end && running))
        else $error("exec_end and running are high together");

    // valid only one cycle after an idle read strobe
    valid_after_read: assert property (@(posedge clk) disable iff (reset)
        data_out_valid && $past(chip_en) |-> $past(!read_write && !scan_start_exec && !running))
        else $error("data_out_valid without a preceding idle read strobe");

endmodule

bind cgra_top cgra_chk i_chk (
    .clk             (clk),
    .reset           (reset),
    .chip_en         (chip_en),
    .read_write      (read_write),
    .scan_start_exec (scan_start_exec),
    .running         (running),
    .exec_end        (exec_end),
    .data_out_valid  (data_out_valid),
    .tile_wr_sel     (tile_wr_sel)
);

`default_nettype wire

// ==== tb_cgra.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cgra;

    // upper estimate of host strobes issued below
    localparam int STROBE_BUDGET   = 1100;
    localparam int MAX_PROG_LEN    = cgra_pkg::CM_DEPTH;
    localparam int WATCHDOG_CYCLES = 50 * (STROBE_BUDGET + MAX_PROG_LEN);

    logic        clk;
    logic        reset;
    logic        chip_en;
    logic        scan_start_exec;
    logic        scan_data_or_addr;
    logic        read_write;
    logic        bist_en;
    logic [31:0] data_in;
    logic [19:0] address_in;
    logic [1:0]  data_addr_valid;
    logic [31:0] data_out;
    logic        data_out_valid;
    logic        exec_end;

    logic [63:0] shadow [4][16];
    logic [31:0] exp_q [$];
    string       name_q [$];
    int          due_q [$];
    logic [31:0] acc_exp [4];
    int          errors = 0;
    int          cycle_cnt = 0;
    int          seed;

    cgra_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .chip_en           (chip_en),
        .scan_start_exec   (scan_start_exec),
        .scan_data_or_addr (scan_data_or_addr),
        .read_write        (read_write),
        .bist_en           (bist_en),
        .data_in           (data_in),
        .address_in        (address_in),
        .data_addr_valid   (data_addr_valid),
        .data_out          (data_out),
        .data_out_valid    (data_out_valid),
        .exec_end          (exec_end)
    );

    always #4 clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [19:0] make_addr(input int region, input int t, input int w,
                                              input int l);
        logic [19:0] a;
        a = '0;
        a[19:18] = region[1:0];
        a[8:7]   = t[1:0];
        a[6:3]   = w[3:0];
        a[2:1]   = l[1:0];
        return a;
    endfunction

    function automatic logic [63:0] make_instr(input cgra_pkg::opcode_e op,
                                               input logic [3:0] target,
                                               input logic [31:0] operand);
        logic [63:0] word;
        word        = '0;
        word[3:0]   = op;
        word[11:8]  = target;
        word[47:16] = operand;
        return word;
    endfunction

    // interprets the shadow program of one tile
    function automatic logic [31:0] expected_acc(input int t);
        logic [63:0] word;
        logic [3:0]  pc;
        logic [31:0] acc;
        pc  = '0;
        acc = '0;
        for (int step = 0; step < 64; step++) begin
            word = shadow[t][pc];
            if (cgra_pkg::opcode_e'(word[3:0]) == cgra_pkg::OP_HALT) begin
                break;
            end
            case (cgra_pkg::opcode_e'(word[3:0]))
                cgra_pkg::OP_ADD: begin
                    acc = acc + word[47:16];
                    pc  = pc + 4'd1;
                end
                cgra_pkg::OP_XOR: begin
                    acc = acc ^ word[47:16];
                    pc  = pc + 4'd1;
                end
                cgra_pkg::OP_JUMP: begin
                    pc = word[11:8];
                end
                default: begin
                    pc = pc + 4'd1;
                end
            endcase
        end
        return acc;
    endfunction

    task automatic drive_idle;
        read_write        = 1'b1;
        scan_start_exec   = 1'b0;
        scan_data_or_addr = 1'b0;
        data_addr_valid   = 2'b00;
    endtask

    task automatic write_raw(input logic [19:0] addr, input logic [15:0] data,
                             input logic [1:0] be, input logic scan);
        logic [31:0] r;
        r = $random(seed);
        @(negedge clk);
        address_in        = addr;
        data_in           = {r[31:16], data};
        data_addr_valid   = be;
        scan_data_or_addr = scan;
        read_write        = 1'b1;
        @(negedge clk);
        drive_idle();
    endtask

    task automatic write_lane(input int t, input int w, input int l, input logic [15:0] data,
                              input logic [1:0] be);
        write_raw(make_addr(0, t, w, l), data, be, 1'b0);
        if (be[0]) begin
            shadow[t][w][l*16 +: 8] = data[7:0];
        end
        if (be[1]) begin
            shadow[t][w][l*16+8 +: 8] = data[15:8];
        end
    endtask

    task automatic write_word(input int t, input int w, input logic [63:0] word);
        for (int l = 0; l < 4; l++) begin
            write_lane(t, w, l, word[l*16 +: 16], 2'b11);
        end
    endtask

    task automatic read_raw(input logic [19:0] addr);
        @(negedge clk);
        address_in      = addr;
        read_write      = 1'b0;
        data_addr_valid = 2'b00;
        @(negedge clk);
        drive_idle();
    endtask

    // data is due one rising edge after the strobe
    task automatic read_expect(input logic [19:0] addr, input logic [31:0] expected,
                               input string name);
        @(negedge clk);
        exp_q.push_back(expected);
        name_q.push_back(name);
        due_q.push_back(cycle_cnt + 1);
        address_in      = addr;
        read_write      = 1'b0;
        data_addr_valid = 2'b00;
        @(negedge clk);
        drive_idle();
    endtask

    task automatic read_lane(input int t, input int w, input int l, input string name);
        read_expect(make_addr(0, t, w, l), {16'h0000, shadow[t][w][l*16 +: 16]}, name);
    endtask

    task automatic load_random_program(input int t, input int len);
        logic [31:0] sel;
        logic [31:0] operand;
        for (int i = 0; i < len; i++) begin
            sel     = $random(seed);
            operand = $random(seed);
            write_word(t, i, make_instr(sel[0] ? cgra_pkg::OP_XOR : cgra_pkg::OP_ADD,
                                        4'h0, operand));
        end
        write_word(t, len, make_instr(cgra_pkg::OP_HALT, 4'h0, 32'h0));
    endtask

    task automatic start_strobe;
        @(negedge clk);
        scan_start_exec = 1'b1;
        @(negedge clk);
        drive_idle();
    endtask

    task automatic wait_exec_end;
        while (!exec_end) begin
            @(negedge clk);
        end
    endtask

    // every valid must match the oldest outstanding read
    always @(negedge clk) begin
        if (data_out_valid) begin
            if (exp_q.size() == 0) begin
                $display("data_out_valid came without a read strobe");
                errors++;
            end else begin
                if (due_q.pop_front() != cycle_cnt) begin
                    $display("data_out_valid for %s did not come one cycle after its read",
                             name_q[0]);
                    errors++;
                end
                compare_value(name_q.pop_front(), exp_q.pop_front(), data_out);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          w;
        int          l;
        seed       = 16;
        clk        = 1'b0;
        reset      = 1'b1;
        chip_en    = 1'b1;
        bist_en    = 1'b0;
        data_in    = '0;
        address_in = '0;
        drive_idle();
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 16; i++) begin
                shadow[t][i] = '0;
            end
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // full lanes everywhere, then read back
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 16; i++) begin
                for (int j = 0; j < 4; j++) begin
                    r = $random(seed);
                    write_lane(t, i, j, r[15:0], 2'b11);
                end
            end
        end
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 16; i++) begin
                for (int j = 0; j < 4; j++) begin
                    read_lane(t, i, j, "full_lane");
                end
            end
        end

        // byte enables and writes that must be dropped
        for (int t = 0; t < 4; t++) begin
            w = t * 3 + 1;
            l = t;
            r = $random(seed);
            write_lane(t, w, l, r[15:0], 2'b01);
            r = $random(seed);
            write_lane(t, w, l, r[15:0], 2'b10);
            r = $random(seed);
            write_raw(make_addr(0, t, w, l), r[15:0], 2'b00, 1'b0);
            write_raw(make_addr(0, t, w, l), r[15:0], 2'b11, 1'b1);
            write_raw(make_addr(1, t, w, l), r[15:0], 2'b11, 1'b0);
            read_lane(t, w, l, "byte_enable");
            read_lane(t, w, (l + 1) % 4, "byte_enable_neighbour");
        end

        // random add/xor programs of different lengths
        for (int t = 0; t < 4; t++) begin
            load_random_program(t, 3 + t * 2);
        end
        start_strobe();
        wait_exec_end();
        for (int t = 0; t < 4; t++) begin
            read_expect(make_addr(1, t, 0, 0), expected_acc(t), "random_program");
        end

        // forward jump skips words 2 and 3
        for (int t = 0; t < 4; t++) begin
            write_word(t, 0, make_instr(cgra_pkg::OP_ADD, 4'h0, $random(seed)));
            write_word(t, 1, make_instr(cgra_pkg::OP_JUMP, 4'h4, 32'h0));
            write_word(t, 2, make_instr(cgra_pkg::OP_ADD, 4'h0, $random(seed)));
            write_word(t, 3, make_instr(cgra_pkg::OP_XOR, 4'h0, $random(seed)));
            write_word(t, 4, make_instr(cgra_pkg::OP_XOR, 4'h0, $random(seed)));
            write_word(t, 5, make_instr(cgra_pkg::OP_HALT, 4'h0, 32'h0));
        end
        start_strobe();
        wait_exec_end();
        for (int t = 0; t < 4; t++) begin
            read_expect(make_addr(1, t, 0, 0), expected_acc(t), "forward_jump");
        end

        // long programs so host strobes land inside the run
        for (int t = 0; t < 4; t++) begin
            load_random_program(t, 12);
            acc_exp[t] = expected_acc(t);
        end
        start_strobe();
        wait_exec_end();
        for (int t = 0; t < 4; t++) begin
            read_expect(make_addr(1, t, 0, 0), acc_exp[t], "rerun_first");
        end
        // exec_end holds until the next start
        compare_value("exec_end_held", 32'd1, {31'd0, exec_end});
        start_strobe();
        r = $random(seed);
        write_raw(make_addr(0, 0, 0, 0), r[15:0], 2'b11, 1'b0);
        read_raw(make_addr(0, 1, 0, 0));
        read_raw(make_addr(1, 2, 0, 0));
        wait_exec_end();
        for (int t = 0; t < 4; t++) begin
            read_expect(make_addr(1, t, 0, 0), acc_exp[t], "rerun_second");
            for (int j = 0; j < 4; j++) begin
                read_lane(t, 0, j, "write_while_running");
            end
        end

        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d reads returned no data", exp_q.size());
            errors += exp_q.size();
        end
        $display("Finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
cgra_pkg.sv
context_mem.sv
cfg_write_decoder.sv
tile.sv
exec_control.sv
readback_mux.sv
cgra_top.sv
cgra_chk.sv
tb_cgra.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cgra \
    -f build.f -o tb_cgra \
    && ./obj_dir/tb_cgra > sim.log 2>&1 \
    && grep -qx "Simulation passed" sim.log \
    && echo "PASS" \
    || { cat sim.log 2>/dev/null; echo "FAIL"; exit 1; }
